// ==== include/core_ref_model.svh ====
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

localparam int unsigned RefXlen = core_cfg_pkg::DefaultXlen;

// architectural effect of one instruction
// pc holds the next pc and is advanced by 4, regs is only read
function automatic void ref_exec(
  input  rv_isa_pkg::instr_t                instr,
  inout  logic [RefXlen-1:0]                pc,
  input  logic [RefXlen-1:0]                regs [core_cfg_pkg::NrRegs],
  output logic [RefXlen-1:0]                exp_pc,
  output logic [core_cfg_pkg::RegAddrW-1:0] exp_rd,
  output logic                              exp_we,
  output logic [RefXlen-1:0]                exp_data,
  output logic                              exp_ex,
  output core_cfg_pkg::cause_t              exp_cause
);
  logic [RefXlen-1:0] a;
  logic [RefXlen-1:0] b;
  logic [RefXlen-1:0] res;
  logic               legal;

  a     = (instr.r.rs1 == '0) ? '0 : regs[instr.r.rs1];
  b     = (instr.r.rs2 == '0) ? '0 : regs[instr.r.rs2];
  res   = '0;
  legal = 1'b1;
  if (instr.r.opcode == rv_isa_pkg::OPCODE_OP) begin
    case ({instr.r.funct7, instr.r.funct3})
      {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB}: res = a + b;
      {rv_isa_pkg::F7_SUB, rv_isa_pkg::F3_ADD_SUB}:  res = a - b;
      {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR}:     res = a ^ b;
      {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR}:      res = a | b;
      {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND}:     res = a & b;
      default:                                       legal = 1'b0;
    endcase
  end else if (instr.i.opcode == rv_isa_pkg::OPCODE_OP_IMM) begin
    // sign-extended immediate
    b = {{(RefXlen-12){instr.i.imm12[11]}}, instr.i.imm12};
    case (instr.i.funct3)
      rv_isa_pkg::F3_ADD_SUB: res = a + b;
      rv_isa_pkg::F3_XOR:     res = a ^ b;
      rv_isa_pkg::F3_OR:      res = a | b;
      rv_isa_pkg::F3_AND:     res = a & b;
      default:                legal = 1'b0;
    endcase
  end else begin
    legal = 1'b0;
  end

  exp_pc    = pc;
  pc        = pc + RefXlen'(4);
  exp_rd    = legal ? instr.r.rd : '0;
  exp_we    = legal && (instr.r.rd != '0);
  exp_data  = exp_we ? res : '0;
  exp_ex    = ~legal;
  exp_cause = legal ? core_cfg_pkg::cause_t'(0) : core_cfg_pkg::CauseIllegalInstr;
endfunction

`endif

// ==== dv/core_tb.sv ====
`timescale 1ns/100ps

module core_tb;
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  `include "core_ref_model.svh"

  localparam int unsigned Xlen = DefaultXlen;
  localparam int InDelay = 2;

  // instruction counts per test
  localparam int NumInit       = NrRegs - 1;
  localparam int NumRand       = 60;
  localparam int NumX0         = 6;
  localparam int NumIllegal    = 8;
  localparam int NumChain      = 40;
  localparam int NumMix        = 30;
  localparam int NumInstrs     = 2 * NumInit + 2 * NumRand + NumX0 + 2 * NumIllegal +
                                 NumChain + NumMix;
  localparam int TimeoutCycles = 8 * NumInstrs + 50;

  typedef struct packed {
    logic [Xlen-1:0]     pc;
    logic [RegAddrW-1:0] rd;
    logic                we;
    logic [Xlen-1:0]     data;
    logic                ex;
    cause_t              cause;
  } retire_rec_t;

  logic                clk_i;
  logic                rst_ni;
  logic [Xlen-1:0]     boot_addr_i;
  logic                instr_valid_i;
  logic                instr_ready_o;
  instr_t              instr_i;
  logic                retire_valid_o;
  logic [Xlen-1:0]     retire_pc_o;
  logic [RegAddrW-1:0] retire_rd_o;
  logic                retire_we_o;
  logic [Xlen-1:0]     retire_wdata_o;
  logic                retire_ex_o;
  cause_t              retire_cause_o;

  // architectural state seen by the reference
  logic [Xlen-1:0] arch_regs [NrRegs];
  logic [Xlen-1:0] next_pc;
  retire_rec_t     exp_q [$];
  string           name_q [$];
  string           test_name;
  int              sent_count    = 0;
  int              retired_count = 0;
  int              cycle_count   = 0;

  core_top #(
    .Xlen           ( Xlen           )
  ) UUT (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_ready_o  ( instr_ready_o  ),
    .instr_i        ( instr_i        ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_we_o    ( retire_we_o    ),
    .retire_wdata_o ( retire_wdata_o ),
    .retire_ex_o    ( retire_ex_o    ),
    .retire_cause_o ( retire_cause_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic end_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(input string test, input string field,
                            input logic [Xlen-1:0] want, input logic [Xlen-1:0] got);
    if (got !== want) begin
      $display("** Error %s: %s expected %h, actual %h", test, field, want, got);
      end_with_failure();
    end
  endtask

  task automatic check_index(input string test, input string field,
                             input logic [RegAddrW-1:0] want, input logic [RegAddrW-1:0] got);
    if (got !== want) begin
      $display("** Error %s: %s expected %0d, actual %0d", test, field, want, got);
      end_with_failure();
    end
  endtask

  task automatic check_cause(input string test, input string field,
                             input cause_t want, input cause_t got);
    if (got !== want) begin
      $display("** Error %s: %s expected %0d, actual %0d", test, field, want, got);
      end_with_failure();
    end
  endtask

  // --------------------------------------------------------------------------
  // instruction encoding
  // --------------------------------------------------------------------------
  function automatic instr_t make_rtype(input logic [6:0] funct7, input logic [2:0] funct3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    instr_t w;
    w.r.funct7 = funct7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = funct3;
    w.r.rd     = rd;
    w.r.opcode = OPCODE_OP;
    return w;
  endfunction

  function automatic instr_t make_itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] funct3, input logic [4:0] rd);
    instr_t w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = funct3;
    w.i.rd     = rd;
    w.i.opcode = OPCODE_OP_IMM;
    return w;
  endfunction

  function automatic logic [2:0] rand_f3();
    case ($urandom_range(0, 3))
      0:       return F3_ADD_SUB;
      1:       return F3_AND;
      2:       return F3_OR;
      default: return F3_XOR;
    endcase
  endfunction

  // one of add, sub, and, or, xor
  function automatic instr_t rand_rtype(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    int unsigned sel;
    logic [2:0]  f3;
    sel = $urandom_range(0, 4);
    case (sel)
      0, 1:    f3 = F3_ADD_SUB;
      2:       f3 = F3_AND;
      3:       f3 = F3_OR;
      default: f3 = F3_XOR;
    endcase
    return make_rtype((sel == 1) ? F7_SUB : F7_BASE, f3, rd, rs1, rs2);
  endfunction

  // --------------------------------------------------------------------------
  // stream driver
  // --------------------------------------------------------------------------
  task automatic apply_reset(input logic [Xlen-1:0] boot);
    rst_ni        = 1'b0;
    boot_addr_i   = boot;
    instr_valid_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #(InDelay);
    rst_ni  = 1'b1;
    next_pc = boot;
  endtask

  // ready is sampled at the falling edge, where it is settled
  task automatic send_instr(input instr_t instr);
    int unsigned gap;
    logic        ready_seen;
    retire_rec_t rec;
    gap = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3);
    repeat (gap) begin
      instr_valid_i = 1'b0;
      instr_i       = instr_t'($urandom);
      @(posedge clk_i);
      #(InDelay);
    end
    instr_valid_i = 1'b1;
    instr_i       = instr;
    ready_seen    = 1'b0;
    while (!ready_seen) begin
      @(negedge clk_i);
      ready_seen = instr_ready_o;
      @(posedge clk_i);
      #(InDelay);
    end
    instr_valid_i = 1'b0;
    ref_exec(instr, next_pc, arch_regs, rec.pc, rec.rd, rec.we, rec.data, rec.ex, rec.cause);
    if (rec.we)
      arch_regs[rec.rd] = rec.data;
    exp_q.push_back(rec);
    name_q.push_back(test_name);
    sent_count++;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #(InDelay);
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic run_init();
    test_name = "init_regs";
    for (int r = 1; r < NrRegs; r++)
      send_instr(make_itype(12'($urandom), 5'd0, F3_ADD_SUB, 5'(r)));
  endtask

  task automatic run_rtype();
    test_name = "rtype_random";
    for (int k = 0; k < NumRand; k++)
      send_instr(rand_rtype(5'($urandom), 5'($urandom), 5'($urandom)));
  endtask

  // the first two immediates are the most negative and minus one
  task automatic run_itype();
    logic [11:0] imm;
    test_name = "itype_random";
    for (int k = 0; k < NumRand; k++) begin
      imm = (k == 0) ? 12'h800 : (k == 1) ? 12'hfff : 12'($urandom);
      send_instr(make_itype(imm, 5'($urandom), rand_f3(), 5'($urandom)));
    end
  endtask

  task automatic run_x0();
    test_name = "x0_write";
    send_instr(make_itype(12'h155, 5'd1, F3_ADD_SUB, 5'd0));
    send_instr(make_rtype(F7_BASE, F3_OR, 5'd0, 5'd2, 5'd3));
    send_instr(make_rtype(F7_SUB, F3_ADD_SUB, 5'd0, 5'd4, 5'd5));
    send_instr(make_rtype(F7_BASE, F3_ADD_SUB, 5'd7, 5'd0, 5'd0));
    send_instr(make_itype(12'h7ff, 5'd0, F3_OR, 5'd8));
    send_instr(make_rtype(F7_BASE, F3_XOR, 5'd9, 5'd0, 5'd1));
  endtask

  // each bad word is followed by a read of its rd field
  task automatic run_illegal();
    instr_t bad [NumIllegal];
    test_name = "illegal_instr";
    bad[0] = instr_t'(32'h0000_2083);
    bad[1] = instr_t'(32'h0010_2023);
    bad[2] = instr_t'(32'h0000_0063);
    bad[3] = instr_t'(32'hffff_ffff);
    bad[4] = make_rtype(F7_BASE, 3'b001, 5'd3, 5'd1, 5'd2);
    bad[5] = make_rtype(F7_SUB, F3_XOR, 5'd4, 5'd1, 5'd2);
    bad[6] = make_rtype(7'b0000001, F3_ADD_SUB, 5'd5, 5'd1, 5'd2);
    bad[7] = make_itype(12'h003, 5'd1, 3'b001, 5'd6);
    for (int k = 0; k < NumIllegal; k++) begin
      send_instr(bad[k]);
      send_instr(rand_rtype(5'($urandom_range(1, NrRegs - 1)), bad[k].r.rd, 5'($urandom)));
    end
  endtask

  task automatic run_chain();
    logic [4:0] prev;
    logic [4:0] rd;
    test_name = "dep_chain";
    prev      = 5'd1;
    for (int k = 0; k < NumChain; k++) begin
      rd = 5'($urandom_range(1, NrRegs - 1));
      if (k % 2 == 0)
        send_instr(rand_rtype(rd, prev, prev));
      else
        send_instr(make_itype(12'($urandom), prev, rand_f3(), rd));
      prev = rd;
    end
  endtask

  task automatic run_mix();
    test_name = "pc_after_reset";
    for (int k = 0; k < NumMix; k++) begin
      case ($urandom_range(0, 2))
        0:       send_instr(rand_rtype(5'($urandom), 5'($urandom), 5'($urandom)));
        1:       send_instr(make_itype(12'($urandom), 5'($urandom), rand_f3(), 5'($urandom)));
        default: send_instr(make_rtype(7'b0000001, F3_ADD_SUB, 5'($urandom), 5'd1, 5'd2));
      endcase
    end
  endtask

  // --------------------------------------------------------------------------
  // retire compare and watchdog
  // --------------------------------------------------------------------------
  initial begin : compare_retire
    retire_rec_t want;
    string       name;
    forever begin
      @(negedge clk_i);
      if (retire_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("retire at pc %h with no instruction outstanding", retire_pc_o);
          end_with_failure();
        end
        want = exp_q.pop_front();
        name = name_q.pop_front();
        check_word(name, "pc", want.pc, retire_pc_o);
        check_index(name, "rd", want.rd, retire_rd_o);
        check_index(name, "we", RegAddrW'(want.we), RegAddrW'(retire_we_o));
        check_word(name, "wdata", want.data, retire_wdata_o);
        check_index(name, "ex", RegAddrW'(want.ex), RegAddrW'(retire_ex_o));
        check_cause(name, "cause", want.cause, retire_cause_o);
        retired_count++;
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count > TimeoutCycles) begin
        $display("timeout after %0d cycles, %0d of %0d instructions retired",
                 cycle_count, retired_count, sent_count);
        end_with_failure();
      end
    end
  end

  initial begin
    rst_ni        = 1'b0;
    boot_addr_i   = '0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    test_name     = "reset";
    void'($urandom(32'h0e16_d686));
    for (int r = 0; r < NrRegs; r++)
      arch_regs[r] = '0;

    apply_reset(32'h0000_1000);
    run_init();
    run_rtype();
    run_itype();
    run_x0();
    run_illegal();
    run_chain();
    wait_drain();

    // restart at another boot address
    apply_reset(32'h8000_0400);
    run_init();
    run_mix();
    wait_drain();

    // a stray retire in this window still fails the compare
    repeat (5) @(posedge clk_i);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== hw/commit_stage.sv ====
`timescale 1ns/100ps

module commit_stage #(
  parameter int unsigned Xlen = core_cfg_pkg::DefaultXlen
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              ex_valid_i,
  input  logic [Xlen-1:0]                   ex_pc_i,
  input  logic [core_cfg_pkg::RegAddrW-1:0] ex_rd_i,
  input  logic [Xlen-1:0]                   ex_result_i,
  input  logic                              ex_ex_i,
  input  core_cfg_pkg::cause_t              ex_cause_i,
  // write-back into the register file
  output logic                              wb_valid_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] wb_rd_o,
  output logic                              wb_we_o,
  output logic [Xlen-1:0]                   wb_data_o,
  // retire report
  output logic                              retire_valid_o,
  output logic [Xlen-1:0]                   retire_pc_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] retire_rd_o,
  output logic                              retire_we_o,
  output logic [Xlen-1:0]                   retire_wdata_o,
  output logic                              retire_ex_o,
  output core_cfg_pkg::cause_t              retire_cause_o
);
  logic we;

  // faulting instructions and x0 targets leave the registers alone
  assign we = (ex_rd_i != '0) & ~ex_ex_i;

  assign wb_valid_o = ex_valid_i;
  assign wb_rd_o    = ex_rd_i;
  assign wb_we_o    = we;
  assign wb_data_o  = ex_result_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= ex_valid_i;
    end
  end

  // data reads as zero when nothing is written
  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      retire_pc_o    <= ex_pc_i;
      retire_rd_o    <= ex_rd_i;
      retire_we_o    <= we;
      retire_wdata_o <= we ? ex_result_i : '0;
      retire_ex_o    <= ex_ex_i;
      retire_cause_o <= ex_cause_i;
    end
  end

  // an exception retires on the next cycle without a write
  a_ex_no_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_valid_i && ex_ex_i |=> retire_valid_o && retire_ex_o && !retire_we_o);

endmodule

// ==== hw/core_cfg_pkg.sv ====
package core_cfg_pkg;

  // ------------------------------------------------------------------------
  // pipeline configuration
  // ------------------------------------------------------------------------
  // data and pc width unless the top level overrides it
  localparam int unsigned DefaultXlen = 32;

  // integer register file
  localparam int unsigned RegAddrW = 5;
  localparam int unsigned NrRegs   = 32;

  // ------------------------------------------------------------------------
  // exception causes
  // ------------------------------------------------------------------------
  typedef logic [3:0] cause_t;

  localparam cause_t CauseIllegalInstr = 4'd2;

endpackage

// ==== hw/core_top.sv ====
`timescale 1ns/100ps

module core_top #(
  parameter int unsigned Xlen = core_cfg_pkg::DefaultXlen
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [Xlen-1:0]                   boot_addr_i,
  input  logic                              instr_valid_i,
  output logic                              instr_ready_o,
  input  rv_isa_pkg::instr_t                instr_i,
  output logic                              retire_valid_o,
  output logic [Xlen-1:0]                   retire_pc_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] retire_rd_o,
  output logic                              retire_we_o,
  output logic [Xlen-1:0]                   retire_wdata_o,
  output logic                              retire_ex_o,
  output core_cfg_pkg::cause_t              retire_cause_o
);
  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  // ------------------------------------------------------------------------
  // stage links
  // ------------------------------------------------------------------------
  // decode to issue
  logic                dec_valid;
  logic                dec_ready;
  logic [Xlen-1:0]     dec_pc;
  logic [RegAddrW-1:0] dec_rd;
  logic [RegAddrW-1:0] dec_rs1;
  logic [RegAddrW-1:0] dec_rs2;
  logic                dec_use_imm;
  logic [Xlen-1:0]     dec_imm;
  alu_op_e             dec_op;
  logic                dec_ex;
  cause_t              dec_cause;
  // issue to execute
  logic                iss_valid;
  logic [Xlen-1:0]     iss_pc;
  logic [RegAddrW-1:0] iss_rd;
  logic [Xlen-1:0]     iss_a;
  logic [Xlen-1:0]     iss_b;
  alu_op_e             iss_op;
  logic                iss_ex;
  cause_t              iss_cause;
  // execute to commit
  logic                ex_valid;
  logic [Xlen-1:0]     ex_pc;
  logic [RegAddrW-1:0] ex_rd;
  logic [Xlen-1:0]     ex_result;
  logic                ex_ex;
  cause_t              ex_cause;
  // commit back to issue
  logic                wb_valid;
  logic [RegAddrW-1:0] wb_rd;
  logic                wb_we;
  logic [Xlen-1:0]     wb_data;

  id_stage #(
    .Xlen          ( Xlen          )
  ) i_id_stage (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .boot_addr_i   ( boot_addr_i   ),
    .instr_valid_i ( instr_valid_i ),
    .instr_ready_o ( instr_ready_o ),
    .instr_i       ( instr_i       ),
    .dec_valid_o   ( dec_valid     ),
    .dec_ready_i   ( dec_ready     ),
    .dec_pc_o      ( dec_pc        ),
    .dec_rd_o      ( dec_rd        ),
    .dec_rs1_o     ( dec_rs1       ),
    .dec_rs2_o     ( dec_rs2       ),
    .dec_use_imm_o ( dec_use_imm   ),
    .dec_imm_o     ( dec_imm       ),
    .dec_op_o      ( dec_op        ),
    .dec_ex_o      ( dec_ex        ),
    .dec_cause_o   ( dec_cause     )
  );

  issue_stage #(
    .Xlen          ( Xlen          )
  ) i_issue_stage (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .dec_valid_i   ( dec_valid     ),
    .dec_ready_o   ( dec_ready     ),
    .dec_pc_i      ( dec_pc        ),
    .dec_rd_i      ( dec_rd        ),
    .dec_rs1_i     ( dec_rs1       ),
    .dec_rs2_i     ( dec_rs2       ),
    .dec_use_imm_i ( dec_use_imm   ),
    .dec_imm_i     ( dec_imm       ),
    .dec_op_i      ( dec_op        ),
    .dec_ex_i      ( dec_ex        ),
    .dec_cause_i   ( dec_cause     ),
    .iss_valid_o   ( iss_valid     ),
    .iss_pc_o      ( iss_pc        ),
    .iss_rd_o      ( iss_rd        ),
    .iss_a_o       ( iss_a         ),
    .iss_b_o       ( iss_b         ),
    .iss_op_o      ( iss_op        ),
    .iss_ex_o      ( iss_ex        ),
    .iss_cause_o   ( iss_cause     ),
    .wb_valid_i    ( wb_valid      ),
    .wb_rd_i       ( wb_rd         ),
    .wb_we_i       ( wb_we         ),
    .wb_data_i     ( wb_data       )
  );

  ex_stage #(
    .Xlen          ( Xlen          )
  ) i_ex_stage (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .iss_valid_i   ( iss_valid     ),
    .iss_pc_i      ( iss_pc        ),
    .iss_rd_i      ( iss_rd        ),
    .iss_a_i       ( iss_a         ),
    .iss_b_i       ( iss_b         ),
    .iss_op_i      ( iss_op        ),
    .iss_ex_i      ( iss_ex        ),
    .iss_cause_i   ( iss_cause     ),
    .ex_valid_o    ( ex_valid      ),
    .ex_pc_o       ( ex_pc         ),
    .ex_rd_o       ( ex_rd         ),
    .ex_result_o   ( ex_result     ),
    .ex_ex_o       ( ex_ex         ),
    .ex_cause_o    ( ex_cause      )
  );

  commit_stage #(
    .Xlen           ( Xlen           )
  ) i_commit_stage (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ex_valid_i     ( ex_valid       ),
    .ex_pc_i        ( ex_pc          ),
    .ex_rd_i        ( ex_rd          ),
    .ex_result_i    ( ex_result      ),
    .ex_ex_i        ( ex_ex          ),
    .ex_cause_i     ( ex_cause       ),
    .wb_valid_o     ( wb_valid       ),
    .wb_rd_o        ( wb_rd          ),
    .wb_we_o        ( wb_we          ),
    .wb_data_o      ( wb_data        ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_we_o    ( retire_we_o    ),
    .retire_wdata_o ( retire_wdata_o ),
    .retire_ex_o    ( retire_ex_o    ),
    .retire_cause_o ( retire_cause_o )
  );

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage #(
  parameter int unsigned Xlen = core_cfg_pkg::DefaultXlen
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              iss_valid_i,
  input  logic [Xlen-1:0]                   iss_pc_i,
  input  logic [core_cfg_pkg::RegAddrW-1:0] iss_rd_i,
  input  logic [Xlen-1:0]                   iss_a_i,
  input  logic [Xlen-1:0]                   iss_b_i,
  input  rv_isa_pkg::alu_op_e               iss_op_i,
  input  logic                              iss_ex_i,
  input  core_cfg_pkg::cause_t              iss_cause_i,
  output logic                              ex_valid_o,
  output logic [Xlen-1:0]                   ex_pc_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] ex_rd_o,
  output logic [Xlen-1:0]                   ex_result_o,
  output logic                              ex_ex_o,
  output core_cfg_pkg::cause_t              ex_cause_o
);
  import rv_isa_pkg::*;

  logic [Xlen-1:0] result;

  // single-cycle alu, wraps at Xlen
  always_comb begin
    case (iss_op_i)
      ALU_SUB: result = iss_a_i - iss_b_i;
      ALU_AND: result = iss_a_i & iss_b_i;
      ALU_OR:  result = iss_a_i | iss_b_i;
      ALU_XOR: result = iss_a_i ^ iss_b_i;
      default: result = iss_a_i + iss_b_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= iss_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (iss_valid_i) begin
      ex_pc_o     <= iss_pc_i;
      ex_rd_o     <= iss_rd_i;
      ex_result_o <= result;
      ex_ex_o     <= iss_ex_i;
      ex_cause_o  <= iss_cause_i;
    end
  end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/100ps

module id_stage #(
  parameter int unsigned Xlen = core_cfg_pkg::DefaultXlen
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [Xlen-1:0]                   boot_addr_i,
  input  logic                              instr_valid_i,
  output logic                              instr_ready_o,
  input  rv_isa_pkg::instr_t                instr_i,
  output logic                              dec_valid_o,
  input  logic                              dec_ready_i,
  output logic [Xlen-1:0]                   dec_pc_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] dec_rd_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] dec_rs1_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] dec_rs2_o,
  output logic                              dec_use_imm_o,
  output logic [Xlen-1:0]                   dec_imm_o,
  output rv_isa_pkg::alu_op_e               dec_op_o,
  output logic                              dec_ex_o,
  output core_cfg_pkg::cause_t              dec_cause_o
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic [Xlen-1:0] pc_q;
  logic            accept;
  logic            legal;
  logic            use_imm;
  alu_op_e         op;

  // entry slot is free or drains this cycle
  assign instr_ready_o = ~dec_valid_o | dec_ready_i;
  assign accept        = instr_valid_i & instr_ready_o;

  // ------------------------------------------------------------------------
  // decoder
  // ------------------------------------------------------------------------
  always_comb begin
    legal   = 1'b0;
    use_imm = 1'b0;
    op      = ALU_ADD;
    case (instr_i.r.opcode)
      OPCODE_OP: begin
        if (instr_i.r.funct7 == F7_BASE) begin
          legal = 1'b1;
          case (instr_i.r.funct3)
            F3_ADD_SUB: op = ALU_ADD;
            F3_XOR:     op = ALU_XOR;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    legal = 1'b0;
          endcase
        end else if (instr_i.r.funct7 == F7_SUB && instr_i.r.funct3 == F3_ADD_SUB) begin
          legal = 1'b1;
          op    = ALU_SUB;
        end
      end
      OPCODE_OP_IMM: begin
        use_imm = 1'b1;
        legal   = 1'b1;
        case (instr_i.i.funct3)
          F3_ADD_SUB: op = ALU_ADD;
          F3_XOR:     op = ALU_XOR;
          F3_OR:      op = ALU_OR;
          F3_AND:     op = ALU_AND;
          default:    legal = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  // pc counter, one step per accepted instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q        <= boot_addr_i;
      dec_valid_o <= 1'b0;
    end else if (accept) begin
      pc_q        <= pc_q + Xlen'(4);
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  // decode register; an illegal entry reads and writes only x0
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_pc_o      <= pc_q;
      dec_rd_o      <= legal ? instr_i.r.rd : '0;
      dec_rs1_o     <= legal ? instr_i.r.rs1 : '0;
      dec_rs2_o     <= (legal && !use_imm) ? instr_i.r.rs2 : '0;
      dec_use_imm_o <= use_imm;
      dec_imm_o     <= {{(Xlen-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
      dec_op_o      <= op;
      dec_ex_o      <= ~legal;
      dec_cause_o   <= legal ? cause_t'(0) : CauseIllegalInstr;
    end
  end

  // a stalled entry must not change under the issue stage
  a_entry_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_pc_o) &&
      $stable(dec_rd_o) && $stable(dec_rs1_o) && $stable(dec_rs2_o) && $stable(dec_op_o));

endmodule

// ==== hw/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage #(
  parameter int unsigned Xlen = core_cfg_pkg::DefaultXlen
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // decoded entry
  input  logic                              dec_valid_i,
  output logic                              dec_ready_o,
  input  logic [Xlen-1:0]                   dec_pc_i,
  input  logic [core_cfg_pkg::RegAddrW-1:0] dec_rd_i,
  input  logic [core_cfg_pkg::RegAddrW-1:0] dec_rs1_i,
  input  logic [core_cfg_pkg::RegAddrW-1:0] dec_rs2_i,
  input  logic                              dec_use_imm_i,
  input  logic [Xlen-1:0]                   dec_imm_i,
  input  rv_isa_pkg::alu_op_e               dec_op_i,
  input  logic                              dec_ex_i,
  input  core_cfg_pkg::cause_t              dec_cause_i,
  // toward execute
  output logic                              iss_valid_o,
  output logic [Xlen-1:0]                   iss_pc_o,
  output logic [core_cfg_pkg::RegAddrW-1:0] iss_rd_o,
  output logic [Xlen-1:0]                   iss_a_o,
  output logic [Xlen-1:0]                   iss_b_o,
  output rv_isa_pkg::alu_op_e               iss_op_o,
  output logic                              iss_ex_o,
  output core_cfg_pkg::cause_t              iss_cause_o,
  // write-back from commit
  input  logic                              wb_valid_i,
  input  logic [core_cfg_pkg::RegAddrW-1:0] wb_rd_i,
  input  logic                              wb_we_i,
  input  logic [Xlen-1:0]                   wb_data_i
);
  import core_cfg_pkg::*;

  logic [Xlen-1:0]   regs_q [NrRegs];
  logic [NrRegs-1:0] busy_q;
  logic              hazard;
  logic              issue;
  logic [Xlen-1:0]   rs1_val;
  logic [Xlen-1:0]   rs2_val;

  // wait until both sources have been written back
  assign hazard      = busy_q[dec_rs1_i] | busy_q[dec_rs2_i];
  assign dec_ready_o = ~hazard;
  assign issue       = dec_valid_i & ~hazard;

  // x0 is hardwired
  assign rs1_val = (dec_rs1_i == '0) ? '0 : regs_q[dec_rs1_i];
  assign rs2_val = (dec_rs2_i == '0) ? '0 : regs_q[dec_rs2_i];

  // ------------------------------------------------------------------------
  // register file and scoreboard
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wb_valid_i && wb_we_i && wb_rd_i != '0) begin
      regs_q[wb_rd_i] <= wb_data_i;
    end
  end

  // a new producer of the same register wins over the release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      // a younger producer still in the issue register keeps the bit
      if (wb_valid_i && wb_we_i && !(iss_valid_o && iss_rd_o == wb_rd_i)) begin
        busy_q[wb_rd_i] <= 1'b0;
      end
      if (issue && dec_rd_i != '0 && !dec_ex_i) begin
        busy_q[dec_rd_i] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // issue register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      iss_valid_o <= 1'b0;
    end else begin
      iss_valid_o <= issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      iss_pc_o    <= dec_pc_i;
      iss_rd_o    <= dec_rd_i;
      iss_a_o     <= rs1_val;
      iss_b_o     <= dec_use_imm_i ? dec_imm_i : rs2_val;
      iss_op_o    <= dec_op_i;
      iss_ex_o    <= dec_ex_i;
      iss_cause_o <= dec_cause_i;
    end
  end

  // x0 never has a pending write
  a_x0_not_busy : assert property (@(posedge clk_i) disable iff (!rst_ni) !busy_q[0]);

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // ------------------------------------------------------------------------
  // major opcodes
  // ------------------------------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  // funct3, shared by register and immediate forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 of the register form
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // ------------------------------------------------------------------------
  // execute operations
  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // ------------------------------------------------------------------------
  // instruction word, register and immediate views
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  typedef union packed {
    rtype_t r;
    itype_t i;
  } instr_t;

endpackage

// ==== verilog.f ====
+incdir+include
hw/core_cfg_pkg.sv
hw/rv_isa_pkg.sv
hw/id_stage.sv
hw/issue_stage.sv
hw/ex_stage.sv
hw/commit_stage.sv
hw/core_top.sv
dv/core_tb.sv
